// ==== logic/branchPkg.sv ====
// Instruction classes, branch condition codes and 2-bit counter encodings for the branch unit
package branchPkg;

	// Instruction class carried with every issued instruction
	typedef enum logic [1:0] {
		CLASS_BRANCH = 2'b00, // Conditional branch
		CLASS_JALR   = 2'b01, // Register-indirect jump, bit 0 cleared
		CLASS_JAL    = 2'b10  // Direct jump
	} instClassT;

	// Branch conditions, funct3 encoding
	localparam logic [2:0] BEQ  = 3'd0;
	localparam logic [2:0] BNE  = 3'd1;
	localparam logic [2:0] BLT  = 3'd2; // Signed
	localparam logic [2:0] BLTU = 3'd3;
	localparam logic [2:0] BGE  = 3'd4; // Signed
	localparam logic [2:0] BGEU = 3'd5;
	// 6 and 7 fall through to always taken

	// Saturating direction counter, MSB is the prediction
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} counterT;

	// PHT entries start here, one miss away from taken
	localparam counterT COUNTER_RESET = WEAK_NT;

endpackage

// ==== logic/branchAlu.sv ====
// Branch ALU: condition evaluation, target, mispredict/misdirect flags, counter update
`timescale 1ns/10ps

module branchAlu #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0]         src1,
	input  logic [XLEN-1:0]         src2,
	input  logic [XLEN-1:0]         pc,
	input  logic [XLEN-1:0]         immExt,
	input  logic [XLEN-1:0]         predictedPC,
	input  branchPkg::instClassT    instClass,
	input  logic [2:0]              funct3,
	input  branchPkg::counterT      predState,
	input  logic                    redirected,
	output logic [XLEN-1:0]         correctAddress,
	output logic [XLEN-1:0]         linkValue,
	output branchPkg::counterT      nextState,
	output logic                    takenBranch,
	output logic                    mispredict,
	output logic                    misdirect,
	output logic                    writeBTB
);

	logic [XLEN-1:0] jumpSum; // Shared adder for JAL and JALR

	assign jumpSum   = src1 + src2;
	assign linkValue = pc + 1'b1; // Word addressed, next instruction

	always_comb begin
		takenBranch    = 1'b0;
		mispredict     = 1'b0;
		misdirect      = 1'b0;
		writeBTB       = 1'b0;
		correctAddress = jumpSum;
		case (instClass)
			branchPkg::CLASS_BRANCH: begin
				correctAddress = pc + immExt; // PC-relative target
				case (funct3)
					branchPkg::BEQ:  takenBranch = (src1 == src2);
					branchPkg::BNE:  takenBranch = (src1 != src2);
					branchPkg::BLT:  takenBranch = ($signed(src1) < $signed(src2));
					branchPkg::BLTU: takenBranch = (src1 < src2);
					branchPkg::BGE:  takenBranch = ($signed(src1) >= $signed(src2));
					branchPkg::BGEU: takenBranch = (src1 >= src2);
					default:         takenBranch = 1'b1; // Codes 6 and 7
				endcase
				// Fetch went to a target that is wrong, or jumped on a fall-through
				misdirect = redirected & ((correctAddress != predictedPC) | !takenBranch);
				mispredict = predState[1] ^ takenBranch; // Direction disagrees
				// Install taken targets, evict entries that redirected a not-taken branch
				writeBTB = takenBranch | redirected;
			end
			branchPkg::CLASS_JALR: begin
				correctAddress = {jumpSum[XLEN-1:1], 1'b0}; // Clear low bit
				takenBranch    = 1'b1;
			end
			branchPkg::CLASS_JAL: begin
				correctAddress = jumpSum; // Low bit kept
				takenBranch    = 1'b1;
			end
			default: begin
				correctAddress = jumpSum;
			end
		endcase
	end

	// Counter moves one step toward the outcome
	always_comb begin
		case (predState)
			branchPkg::STRONG_T: begin
				nextState = takenBranch ? branchPkg::STRONG_T : branchPkg::WEAK_T;
			end
			branchPkg::WEAK_T: begin
				nextState = takenBranch ? branchPkg::STRONG_T : branchPkg::WEAK_NT;
			end
			branchPkg::WEAK_NT: begin
				nextState = takenBranch ? branchPkg::WEAK_T : branchPkg::STRONG_NT;
			end
			default: begin // Strongly not taken
				nextState = takenBranch ? branchPkg::WEAK_NT : branchPkg::STRONG_NT;
			end
		endcase
	end

endmodule

// ==== logic/predictorTable.sv ====
// Direct-mapped predictor table with async read and sync write, shared by BTB and PHT
`timescale 1ns/10ps

module predictorTable #(
	parameter int  INDEX_BITS  = 4,
	parameter type entryT      = logic [1:0],
	parameter entryT RESET_VALUE = '0
) (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [INDEX_BITS-1:0] readIndex,
	input  logic                  writeEnable,
	input  logic [INDEX_BITS-1:0] writeIndex,
	input  entryT                 writeData,
	output entryT                 readData
);

	localparam int ENTRIES = 2 ** INDEX_BITS;

	entryT entries [ENTRIES]; // One entry per index

	// Fetch sees the table in the same cycle
	assign readData = entries[readIndex];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			// Whole table returns to its known state
			for (int i = 0; i < ENTRIES; i++) begin
				entries[i] <= RESET_VALUE;
			end
		end else if (writeEnable) begin
			entries[writeIndex] <= writeData; // Update at resolution
		end
	end

endmodule

// ==== logic/resultFifo.sv ====
// Circular FIFO holding link results until the common data bus grants them
`timescale 1ns/10ps

module resultFifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 36
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       push,
	input  logic [WIDTH-1:0]           pushData,
	input  logic                       pop,
	output logic [WIDTH-1:0]           popData,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]     mem [DEPTH]; // Payload storage
	logic [PTR_WIDTH-1:0] rdPtr;       // Head
	logic [PTR_WIDTH-1:0] wrPtr;       // Next free slot
	logic                 doPush;
	logic                 doPop;

	// Wraps at DEPTH, also for non power of two depths
	function automatic logic [PTR_WIDTH-1:0] bumpPtr(input logic [PTR_WIDTH-1:0] ptr);
		return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign doPush  = push & (int'(count) < DEPTH); // Full guard
	assign doPop   = pop & !empty;
	assign popData = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= bumpPtr(wrPtr);
			if (doPop) rdPtr <= bumpPtr(rdPtr);
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData;
	end

endmodule

// ==== logic/branchCtrl.sv ====
// Branch control: resolve-stage register, issue gating, registered flush, table and FIFO strobes
`timescale 1ns/10ps

module branchCtrl #(
	parameter int XLEN       = 32,
	parameter int TAG_WIDTH  = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           rstN,
	// Issue port
	input  logic                           issueValid,
	input  logic [XLEN-1:0]                src1,
	input  logic [XLEN-1:0]                src2,
	input  logic [XLEN-1:0]                pc,
	input  logic [XLEN-1:0]                immExt,
	input  branchPkg::instClassT           instClass,
	input  logic [2:0]                     funct3,
	input  branchPkg::counterT             predState,
	input  logic                           redirected,
	input  logic [XLEN-1:0]                predictedPC,
	input  logic [TAG_WIDTH-1:0]           tag,
	output logic                           issueReady,
	// ALU results for the staged instruction
	input  logic [XLEN-1:0]                correctAddress,
	input  logic [XLEN-1:0]                linkValue,
	input  logic                           takenBranch,
	input  logic                           mispredict,
	input  logic                           misdirect,
	input  logic                           writeBTB,
	input  branchPkg::counterT             nextState,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifoCount,
	// Stage fields feeding the ALU
	output logic [XLEN-1:0]                stSrc1,
	output logic [XLEN-1:0]                stSrc2,
	output logic [XLEN-1:0]                stPc,
	output logic [XLEN-1:0]                stImm,
	output logic [XLEN-1:0]                stPredictedPC,
	output branchPkg::instClassT           stClass,
	output logic [2:0]                     stFunct3,
	output branchPkg::counterT             stState,
	output logic                           stRedirected,
	// Fetch redirect
	output logic                           flushValid,
	output logic [XLEN-1:0]                flushTarget,
	// Table and FIFO strobes
	output logic                           phtWrite,
	output logic                           btbWrite,
	output logic                           btbValidBit,
	output logic                           fifoPush,
	output logic [TAG_WIDTH+XLEN-1:0]      fifoData
);

	logic                 stValid; // Resolve stage occupied
	logic [TAG_WIDTH-1:0] stTag;
	logic                 accept;
	logic                 isBranch;

	// Staged item always lands in the FIFO next edge, so reserve a slot for it
	assign issueReady = (int'(fifoCount) + int'(stValid)) < FIFO_DEPTH;
	assign accept     = issueValid & issueReady;
	assign isBranch   = (stClass == branchPkg::CLASS_BRANCH);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stValid <= 1'b0;
		end else begin
			stValid <= accept; // One cycle in the resolve stage
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			stSrc1        <= src1;
			stSrc2        <= src2;
			stPc          <= pc;
			stImm         <= immExt;
			stPredictedPC <= predictedPC;
			stClass       <= instClass;
			stFunct3      <= funct3;
			stState       <= predState;
			stRedirected  <= redirected;
			stTag         <= tag;
		end
	end

	// Flush pulses for exactly the cycle after resolution
	always_ff @(posedge clk) begin
		if (!rstN) begin
			flushValid <= 1'b0;
		end else begin
			flushValid <= stValid & (mispredict | misdirect);
		end
	end

	always_ff @(posedge clk) begin
		if (stValid) begin
			flushTarget <= takenBranch ? correctAddress : linkValue; // Fall through is pc+1
		end
	end

	// Every resolved branch rewrites its counter
	assign phtWrite    = stValid & isBranch;
	assign btbWrite    = stValid & isBranch & writeBTB;
	assign btbValidBit = takenBranch; // Not-taken redirect clears the entry

	// Every class returns its link value on the bus
	assign fifoPush = stValid;
	assign fifoData = {stTag, linkValue};

endmodule

// ==== logic/branchUnit.sv ====
// Branch unit top: BTB entry type, lookup hit compare, ALU, control, tables and result FIFO
`timescale 1ns/10ps

module branchUnit #(
	parameter int XLEN           = 32,
	parameter int TAG_WIDTH      = 4,
	parameter int BTB_INDEX_BITS = 4,
	parameter int PHT_INDEX_BITS = 6,
	parameter int FIFO_DEPTH     = 4
) (
	input  logic                 clk,
	input  logic                 rstN,
	// Fetch lookup
	input  logic [XLEN-1:0]      lookupPC,
	output logic                 btbHit,
	output logic [XLEN-1:0]      btbTarget,
	output branchPkg::counterT   phtState,
	// Issue
	input  logic                 issueValid,
	input  logic [XLEN-1:0]      src1,
	input  logic [XLEN-1:0]      src2,
	input  logic [XLEN-1:0]      pc,
	input  logic [XLEN-1:0]      immExt,
	input  branchPkg::instClassT instClass,
	input  logic [2:0]           funct3,
	input  branchPkg::counterT   predState,
	input  logic                 redirected,
	input  logic [XLEN-1:0]      predictedPC,
	input  logic [TAG_WIDTH-1:0] tag,
	output logic                 issueReady,
	// Fetch redirect
	output logic                 flushValid,
	output logic [XLEN-1:0]      flushTarget,
	// Common data bus
	input  logic                 cdbGrant,
	output logic                 cdbValid,
	output logic [TAG_WIDTH-1:0] cdbTag,
	output logic [XLEN-1:0]      cdbValue
);

	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
	localparam int BTB_TAG_BITS = XLEN - BTB_INDEX_BITS;

	typedef struct packed {
		logic                    valid;
		logic [BTB_TAG_BITS-1:0] tag;    // Upper PC bits
		logic [XLEN-1:0]         target;
	} btbEntryT;

	// Stage fields
	logic [XLEN-1:0]      stSrc1;
	logic [XLEN-1:0]      stSrc2;
	logic [XLEN-1:0]      stPc;
	logic [XLEN-1:0]      stImm;
	logic [XLEN-1:0]      stPredictedPC;
	branchPkg::instClassT stClass;
	logic [2:0]           stFunct3;
	branchPkg::counterT   stState;
	logic                 stRedirected;
	// ALU outputs
	logic [XLEN-1:0]      correctAddress;
	logic [XLEN-1:0]      linkValue;
	branchPkg::counterT   nextState;
	logic                 takenBranch;
	logic                 mispredict;
	logic                 misdirect;
	logic                 writeBTB;
	// Table writes and lookup
	logic                 phtWrite;
	logic                 btbWrite;
	logic                 btbValidBit;
	btbEntryT             btbWriteData;
	btbEntryT             btbReadData;
	// FIFO
	logic                 fifoPush;
	logic [TAG_WIDTH+XLEN-1:0] fifoData;
	logic [TAG_WIDTH+XLEN-1:0] fifoHead;
	logic                 fifoEmpty;
	logic [COUNT_WIDTH-1:0] fifoCount;

	// Hit needs a live entry whose tag matches the upper PC bits
	assign btbHit    = btbReadData.valid &
		(btbReadData.tag == lookupPC[XLEN-1:BTB_INDEX_BITS]);
	assign btbTarget = btbReadData.target;

	assign btbWriteData = '{valid: btbValidBit, tag: stPc[XLEN-1:BTB_INDEX_BITS],
		target: correctAddress};

	assign cdbValid = !fifoEmpty; // Request level to the arbiter
	assign cdbTag   = fifoHead[TAG_WIDTH+XLEN-1:XLEN];
	assign cdbValue = fifoHead[XLEN-1:0];

	branchCtrl #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_ctrl (
		.clk, .rstN,
		.issueValid, .src1, .src2, .pc, .immExt, .instClass, .funct3,
		.predState, .redirected, .predictedPC, .tag, .issueReady,
		.correctAddress, .linkValue, .takenBranch, .mispredict, .misdirect,
		.writeBTB, .nextState, .fifoCount,
		.stSrc1, .stSrc2, .stPc, .stImm, .stPredictedPC, .stClass, .stFunct3,
		.stState, .stRedirected,
		.flushValid, .flushTarget,
		.phtWrite, .btbWrite, .btbValidBit, .fifoPush, .fifoData
	);

	branchAlu #(.XLEN(XLEN)) u_alu (
		.src1(stSrc1), .src2(stSrc2), .pc(stPc), .immExt(stImm),
		.predictedPC(stPredictedPC), .instClass(stClass), .funct3(stFunct3),
		.predState(stState), .redirected(stRedirected),
		.correctAddress, .linkValue, .nextState, .takenBranch,
		.mispredict, .misdirect, .writeBTB
	);

	predictorTable #(
		.INDEX_BITS(BTB_INDEX_BITS), .entryT(btbEntryT), .RESET_VALUE(btbEntryT'('0))
	) u_btb (
		.clk, .rstN,
		.readIndex(lookupPC[BTB_INDEX_BITS-1:0]),
		.writeEnable(btbWrite),
		.writeIndex(stPc[BTB_INDEX_BITS-1:0]),
		.writeData(btbWriteData),
		.readData(btbReadData)
	);

	predictorTable #(
		.INDEX_BITS(PHT_INDEX_BITS), .entryT(branchPkg::counterT),
		.RESET_VALUE(branchPkg::COUNTER_RESET)
	) u_pht (
		.clk, .rstN,
		.readIndex(lookupPC[PHT_INDEX_BITS-1:0]),
		.writeEnable(phtWrite),
		.writeIndex(stPc[PHT_INDEX_BITS-1:0]),
		.writeData(nextState),
		.readData(phtState)
	);

	resultFifo #(.DEPTH(FIFO_DEPTH), .WIDTH(TAG_WIDTH + XLEN)) u_fifo (
		.clk, .rstN,
		.push(fifoPush), .pushData(fifoData),
		.pop(cdbValid & cdbGrant), // Head leaves on a granted cycle
		.popData(fifoHead), .empty(fifoEmpty), .count(fifoCount)
	);

endmodule

// ==== verif/branchChecker.sv ====
// Checker: reference model, shadow BTB and PHT, expected bus queue, comparisons against the DUT
`timescale 1ns/10ps

module branchChecker #(
	parameter int XLEN           = 32,
	parameter int TAG_WIDTH      = 4,
	parameter int BTB_INDEX_BITS = 4,
	parameter int PHT_INDEX_BITS = 6
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 issueValid,
	input  logic                 issueReady,
	input  logic [XLEN-1:0]      src1,
	input  logic [XLEN-1:0]      src2,
	input  logic [XLEN-1:0]      pc,
	input  logic [XLEN-1:0]      immExt,
	input  logic [XLEN-1:0]      predictedPC,
	input  branchPkg::instClassT instClass,
	input  logic [2:0]           funct3,
	input  branchPkg::counterT   predState,
	input  logic                 redirected,
	input  logic [TAG_WIDTH-1:0] tag,
	input  logic [XLEN-1:0]      lookupPC,
	input  logic                 btbHit,
	input  logic [XLEN-1:0]      btbTarget,
	input  branchPkg::counterT   phtState,
	input  logic                 flushValid,
	input  logic [XLEN-1:0]      flushTarget,
	input  logic [XLEN-1:0]      aluTarget, // Probe on the ALU target
	input  logic                 cdbValid,
	input  logic                 cdbGrant,
	input  logic [TAG_WIDTH-1:0] cdbTag,
	input  logic [XLEN-1:0]      cdbValue,
	output int                   errors,
	output int                   pending
);

	localparam int BTB_TAG_BITS = XLEN - BTB_INDEX_BITS;

	logic                    bValid [2**BTB_INDEX_BITS]; // Shadow BTB
	logic [BTB_TAG_BITS-1:0] bTag [2**BTB_INDEX_BITS];
	logic [XLEN-1:0]         bTgt [2**BTB_INDEX_BITS];
	logic [1:0]              pht [2**PHT_INDEX_BITS];   // Shadow PHT
	logic [TAG_WIDTH+XLEN-1:0] expQ [$];                // Bus results in issue order
	logic [TAG_WIDTH+XLEN-1:0] expBus;
	logic                    s1Valid, s1Taken, s1Flush, s1Redir; // Item in the resolve stage
	logic                    s2Valid, s2Flush;                   // Item whose flush shows now
	logic [XLEN-1:0]         s1Pc, s1Target, s1FlushTgt, s2FlushTgt;
	logic [1:0]              s1State, nextCnt;
	branchPkg::instClassT    s1Class;
	logic                    expHit;
	logic [BTB_INDEX_BITS-1:0] bIdx;

	// Outcome, target and flush from the instruction rules
	function automatic void resolveRef(
		input branchPkg::instClassT cls, input logic [2:0] f3,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] p, input logic [XLEN-1:0] imm, input logic [XLEN-1:0] ppc,
		input logic [1:0] pst, input logic redir,
		output logic taken, output logic [XLEN-1:0] target,
		output logic flush, output logic [XLEN-1:0] flushTgt);
		logic lessS;
		logic lessU;
		lessS = $signed(a) < $signed(b);
		lessU = a < b;
		taken = 1'b1;
		flush = 1'b0;
		if (cls == branchPkg::CLASS_BRANCH) begin
			target = p + imm;
			case (f3)
				branchPkg::BEQ:  taken = (a == b);
				branchPkg::BNE:  taken = (a != b);
				branchPkg::BLT:  taken = lessS;
				branchPkg::BLTU: taken = lessU;
				branchPkg::BGE:  taken = !lessS;
				branchPkg::BGEU: taken = !lessU;
				default:         taken = 1'b1; // Always taken
			endcase
			flush = (pst[1] != taken) || (redir && (!taken || ppc != target));
		end else if (cls == branchPkg::CLASS_JALR) begin
			target = (a + b) & ~XLEN'(1); // Even target
		end else begin
			target = a + b;
		end
		flushTgt = taken ? target : p + 1'b1;
	endfunction

	// One step toward the outcome, stuck at the ends
	function automatic logic [1:0] stepCounter(input logic [1:0] cnt, input logic taken);
		if (taken) begin
			return (cnt == 2'b11) ? cnt : cnt + 1'b1;
		end
		return (cnt == 2'b00) ? cnt : cnt - 1'b1;
	endfunction

	task automatic reportMismatch(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 2**BTB_INDEX_BITS; i++) bValid[i] = 1'b0;
			for (int j = 0; j < 2**PHT_INDEX_BITS; j++) pht[j] = branchPkg::COUNTER_RESET;
			s1Valid = 1'b0;
			s2Valid = 1'b0;
			expQ.delete();
			errors = 0;
		end else begin
			// Lookup port against shadow tables as they stood before this edge
			bIdx = lookupPC[BTB_INDEX_BITS-1:0];
			expHit = bValid[bIdx] && (bTag[bIdx] == lookupPC[XLEN-1:BTB_INDEX_BITS]);
			if (btbHit !== expHit) reportMismatch("btbHit", btbHit, expHit);
			if (expHit && btbTarget !== bTgt[bIdx]) reportMismatch("btbTarget", btbTarget, bTgt[bIdx]);
			if (phtState !== pht[lookupPC[PHT_INDEX_BITS-1:0]]) begin
				reportMismatch("phtState", phtState, pht[lookupPC[PHT_INDEX_BITS-1:0]]);
			end
			// Flush belongs to the item accepted two edges back
			if (flushValid !== (s2Valid && s2Flush)) begin
				reportMismatch("flushValid", flushValid, s2Valid && s2Flush);
			end
			if (s2Valid && s2Flush && flushTarget !== s2FlushTgt) begin
				reportMismatch("flushTarget", flushTarget, s2FlushTgt);
			end
			if (s1Valid && aluTarget !== s1Target) reportMismatch("aluTarget", aluTarget, s1Target);
			// Staged item is queued here but reaches the FIFO only at this edge
			if (cdbValid !== (expQ.size() > int'(s1Valid))) begin
				reportMismatch("cdbValid", cdbValid, expQ.size() > int'(s1Valid));
			end
			if (cdbValid && cdbGrant) begin
				if (expQ.size() == 0) begin
					$display("Bus delivered a result while none was outstanding at %0t", $time);
					errors++;
				end else begin
					expBus = expQ.pop_front();
					if (cdbTag !== expBus[TAG_WIDTH+XLEN-1:XLEN]) begin
						reportMismatch("cdbTag", cdbTag, expBus[TAG_WIDTH+XLEN-1:XLEN]);
					end
					if (cdbValue !== expBus[XLEN-1:0]) reportMismatch("cdbValue", cdbValue, expBus[XLEN-1:0]);
				end
			end
			// Tables take the staged branch at this edge
			if (s1Valid && s1Class == branchPkg::CLASS_BRANCH) begin
				nextCnt = stepCounter(s1State, s1Taken);
				pht[s1Pc[PHT_INDEX_BITS-1:0]] = nextCnt; // Every branch writes
				if (s1Taken || s1Redir) begin
					bValid[s1Pc[BTB_INDEX_BITS-1:0]] = s1Taken; // Not taken evicts
					bTag[s1Pc[BTB_INDEX_BITS-1:0]]   = s1Pc[XLEN-1:BTB_INDEX_BITS];
					bTgt[s1Pc[BTB_INDEX_BITS-1:0]]   = s1Target;
				end
			end
			s2Valid    = s1Valid;
			s2Flush    = s1Flush;
			s2FlushTgt = s1FlushTgt;
			s1Valid    = issueValid && issueReady; // Accepted at this edge
			if (s1Valid) begin
				resolveRef(instClass, funct3, src1, src2, pc, immExt, predictedPC, predState,
					redirected, s1Taken, s1Target, s1Flush, s1FlushTgt);
				s1Pc    = pc;
				s1Class = instClass;
				s1State = predState;
				s1Redir = redirected;
				expQ.push_back({tag, pc + 1'b1}); // Link value, word addressed
			end
		end
		pending = expQ.size();
	end

endmodule

// ==== verif/branchUnitTb.sv ====
// Testbench top: clock, reset, random issue stimulus, bus grant pattern, timeout and report
`timescale 1ns/10ps

module branchUnitTb;

	localparam int XLEN           = 32;
	localparam int TAG_WIDTH      = 4;
	localparam int BTB_INDEX_BITS = 4;
	localparam int PHT_INDEX_BITS = 6;
	localparam int FIFO_DEPTH     = 4;
	localparam int NUM_BRANCH     = 600;
	localparam int NUM_JALR       = 100;
	localparam int NUM_JAL        = 50;
	localparam int BURST_LEN      = 8;
	localparam int BURST_HOLD     = 20; // Cycles the bus stays blocked
	localparam int TOTAL_OPS      = NUM_BRANCH + NUM_JALR + NUM_JAL + BURST_LEN;
	localparam int CYCLE_LIMIT    = 25 * TOTAL_OPS + 1050; // About 25 cycles per instruction

	logic clk, rstN, issueValid, redirected, issueReady, btbHit, flushValid;
	logic cdbGrant, cdbValid;
	logic [XLEN-1:0] lookupPC, src1, src2, pc, immExt, predictedPC, btbTarget;
	logic [XLEN-1:0] flushTarget, cdbValue;
	logic [TAG_WIDTH-1:0] tag, cdbTag, nextTag;
	logic [2:0] funct3;
	branchPkg::instClassT instClass;
	branchPkg::counterT predState, phtState;
	integer seed;
	int chkErrors, pending, tbErrors, cycles;
	logic holdGrant, sawReadyLow;
	logic [XLEN-1:0] lastPc, olderPc, opA, opB, pcV, immV, rnd;

	branchUnit #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH), .BTB_INDEX_BITS(BTB_INDEX_BITS),
		.PHT_INDEX_BITS(PHT_INDEX_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_dut (.*);

	branchChecker #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH), .BTB_INDEX_BITS(BTB_INDEX_BITS),
		.PHT_INDEX_BITS(PHT_INDEX_BITS)) u_chk (.*, .aluTarget(u_dut.correctAddress),
		.errors(chkErrors), .pending(pending));

	always #10 clk = ~clk; // 20 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Arbiter grants about three cycles in four unless blocked
	always @(posedge clk) begin
		#2;
		cdbGrant = !holdGrant && (($random(seed) & 3) != 0);
	end

	always @(posedge clk) begin
		if (rstN && holdGrant && !issueReady) sawReadyLow = 1'b1;
	end

	// Zero, sign boundaries, the other operand, or random
	function automatic logic [XLEN-1:0] pickOperand(input logic [XLEN-1:0] other);
		int sel;
		sel = $random(seed) & 7;
		case (sel)
			0: return '0;
			1: return 32'h7fff_ffff;
			2: return 32'h8000_0000;
			3: return 32'hffff_ffff;
			4: return other; // Equal operands
			default: return $random(seed);
		endcase
	endfunction

	// Holds the issue until accepted, returns 2 ns after the accepting edge
	task automatic issueOne(input branchPkg::instClassT cls, input logic [2:0] f3,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] p,
		input logic [XLEN-1:0] imm, input logic [1:0] pst, input logic redir,
		input logic [XLEN-1:0] ppc);
		lookupPC    = olderPc; // Already written back by now
		instClass   = cls;
		funct3      = f3;
		src1        = a;
		src2        = b;
		pc          = p;
		immExt      = imm;
		predState   = branchPkg::counterT'(pst);
		redirected  = redir;
		predictedPC = ppc;
		tag         = nextTag;
		issueValid  = 1'b1;
		do @(posedge clk); while (!issueReady);
		#2;
		issueValid = 1'b0;
		olderPc    = lastPc;
		lastPc     = p;
		nextTag++;
	endtask

	initial begin
		seed = 32'h3572;
		{clk, rstN, issueValid, redirected, cdbGrant, holdGrant, sawReadyLow} = '0;
		{lookupPC, src1, src2, pc, immExt, predictedPC, lastPc, olderPc} = '0;
		instClass = branchPkg::CLASS_BRANCH;
		predState = branchPkg::COUNTER_RESET;
		{funct3, tag, nextTag} = '0;
		tbErrors = 0;
		cycles   = 0;
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
		for (int n = 0; n < NUM_BRANCH; n++) begin
			rnd  = $random(seed);
			opB  = $random(seed);
			opA  = pickOperand(opB);
			opB  = pickOperand(opA);
			pcV  = $random(seed) & 32'hff; // Small pool so entries get reused
			immV = {{(XLEN-8){rnd[7]}}, rnd[7:0]};
			issueOne(branchPkg::CLASS_BRANCH, rnd[10:8], opA, opB, pcV, immV, rnd[12:11],
				rnd[13], rnd[14] ? pcV + immV : $random(seed));
			if (rnd[17:15] == 0) begin
				@(posedge clk);
				#2;
			end
		end
		for (int n = 0; n < NUM_JALR + NUM_JAL; n++) begin
			rnd = $random(seed);
			opA = $random(seed);
			opB = $random(seed) & 32'hff;
			pcV = $random(seed) & 32'hff;
			if (n < NUM_JALR) begin
				issueOne(branchPkg::CLASS_JALR, 3'd0, opA, opB, pcV, '0, rnd[1:0], rnd[2], opA);
			end else begin
				issueOne(branchPkg::CLASS_JAL, 3'd0, opA, opB, pcV, '0, rnd[1:0], rnd[2], opA);
			end
		end
		// Bus blocked long enough to fill the FIFO and stall issue
		holdGrant   = 1'b1;
		sawReadyLow = 1'b0;
		fork
			begin
				for (int n = 0; n < BURST_LEN; n++) begin
					issueOne(branchPkg::CLASS_JAL, 3'd0, $random(seed), n, 32'h40 + n, '0,
						2'b00, 1'b0, '0);
				end
			end
			begin
				repeat (BURST_HOLD) @(posedge clk);
				#2;
				if (!sawReadyLow) begin
					$display("issueReady never dropped while the bus was held off");
					tbErrors++;
				end
				holdGrant = 1'b0;
			end
		join
		while (pending != 0) begin
			@(posedge clk);
			#2;
		end
		repeat (4) @(posedge clk); // Let the last flush window pass
		$display("Errors: %0d from the checker, %0d from the testbench", chkErrors, tbErrors);
		if (chkErrors + tbErrors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/branchPkg.sv
logic/branchAlu.sv
logic/predictorTable.sv
logic/resultFifo.sv
logic/branchCtrl.sv
logic/branchUnit.sv
verif/branchChecker.sv
verif/branchUnitTb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - logic/branchPkg.sv
  - logic/branchAlu.sv
  - logic/predictorTable.sv
  - logic/resultFifo.sv
  - logic/branchCtrl.sv
  - logic/branchUnit.sv
  - target: test
    files:
      - verif/branchChecker.sv
      - verif/branchUnitTb.sv
